/* hw/qproc_mem_defines.svh */
`ifndef QPROC_MEM_DEFINES_SVH
`define QPROC_MEM_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Widths

`define QPROC_DW           32   // AXI data, stream data, memory word
`define QPROC_AXI_AW       8
`define MEM_ADDR_W         16   // MEM_ADDR and MEM_LEN

// Memory address widths
`define PMEM_AW            8
`define DMEM_AW            4
`define WMEM_AW            4

//////////////////////////////////////////////////////////////////////
// Register byte offsets

`define REG_TPROC_CFG      8'd4
`define REG_MEM_ADDR       8'd8
`define REG_MEM_LEN        8'd12
`define REG_MEM_DT_I       8'd16
`define REG_MEM_DT_O       8'd40
`define REG_TPROC_STATUS   8'd56

`endif

/* hw/qproc_mem_pkg.sv */
package qproc_mem_pkg;

   // Target memory, same code as the TPROC_CFG sel field
   typedef enum logic [1:0] {
      MEM_NONE = 2'd0,
      MEM_PMEM = 2'd1,
      MEM_DMEM = 2'd2,
      MEM_WMEM = 2'd3
   } mem_sel_t;

   // Low bits of TPROC_CFG, start is bit 0
   typedef struct packed {
      logic     single;   // 1 register transfer, 0 stream
      mem_sel_t sel;
      logic     write;
      logic     start;
   } mem_cfg_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      SGL,      // single word
      STR_WR,   // stream in from DMA
      STR_RD    // stream out to DMA
   } ctrl_state_t;

endpackage

/* hw/qproc_mem_ifs.sv */
`include "qproc_mem_defines.svh"

//////////////////////////////////////////////////////////////////////
// Register file to controller

interface mem_cfg_if;
   import qproc_mem_pkg::*;

   logic                   op_start;   // one cycle on TPROC_CFG start
   mem_cfg_t               cfg;
   logic [`MEM_ADDR_W-1:0] base_addr;
   logic [`MEM_ADDR_W-1:0] len;
   logic [`QPROC_DW-1:0]   wr_data;
   logic                   busy;
   logic [`QPROC_DW-1:0]   rd_data;
   logic                   rd_valid;   // loads MEM_DT_O

   modport regs (output op_start, cfg, base_addr, len, wr_data,
                 input  busy, rd_data, rd_valid);
   modport ctrl (input  op_start, cfg, base_addr, len, wr_data,
                 output busy, rd_data, rd_valid);
endinterface

//////////////////////////////////////////////////////////////////////
// Controller to memory bank

interface mem_port_if;
   import qproc_mem_pkg::*;

   logic                   en;
   logic                   we;
   mem_sel_t               sel;
   logic [`MEM_ADDR_W-1:0] addr;
   logic [`QPROC_DW-1:0]   wdata;
   logic [`QPROC_DW-1:0]   rdata;   // one cycle after en

   modport master (output en, we, sel, addr, wdata, input rdata);
   modport slave  (input en, we, sel, addr, wdata, output rdata);
endinterface

/* hw/axil_reg_file.sv */
`include "qproc_mem_defines.svh"

module axil_reg_file (
   input  logic                    s_ps_dma_aclk,
   input  logic                    rst_n_i,
   input  logic [`QPROC_AXI_AW-1:0] s_axi_awaddr_i,
   input  logic                    s_axi_awvalid_i,
   output logic                    s_axi_awready_o,
   input  logic [`QPROC_DW-1:0]    s_axi_wdata_i,
   input  logic                    s_axi_wvalid_i,
   output logic                    s_axi_wready_o,
   output logic                    s_axi_bvalid_o,
   output logic [1:0]              s_axi_bresp_o,
   input  logic                    s_axi_bready_i,
   input  logic [`QPROC_AXI_AW-1:0] s_axi_araddr_i,
   input  logic                    s_axi_arvalid_i,
   output logic                    s_axi_arready_o,
   output logic                    s_axi_rvalid_o,
   output logic [`QPROC_DW-1:0]    s_axi_rdata_o,
   output logic [1:0]              s_axi_rresp_o,
   input  logic                    s_axi_rready_i,
   mem_cfg_if.regs                 cfg_if
);
   import qproc_mem_pkg::*;

   localparam int PAD_A = `QPROC_DW - `MEM_ADDR_W;
   localparam int PAD_C = `QPROC_DW - $bits(mem_cfg_t);

   // Handshake state
   logic aw_rdy_q, bvalid_q;
   logic ar_rdy_q, rvalid_q;
   logic wr_hs, rd_hs;
   logic op_start_q;

   // Registers
   logic [`MEM_ADDR_W-1:0] mem_addr_q;
   logic [`MEM_ADDR_W-1:0] mem_len_q;
   logic [`QPROC_DW-1:0]   mem_dt_i_q;
   logic [`QPROC_DW-1:0]   mem_dt_o_q;
   mem_cfg_t               cfg_q;
   mem_cfg_t               wr_cfg;
   logic [`QPROC_DW-1:0]   rd_mux, rdata_q;

   assign wr_hs  = aw_rdy_q & s_axi_awvalid_i & s_axi_wvalid_i;
   assign rd_hs  = ar_rdy_q & s_axi_arvalid_i;
   assign wr_cfg = mem_cfg_t'(s_axi_wdata_i[$bits(mem_cfg_t)-1:0]);

   //////////////////////////////////////////////////////////////////////
   // AXI-Lite handshakes and control registers

   always_ff @(posedge s_ps_dma_aclk) begin
      if (!rst_n_i) begin
         aw_rdy_q   <= 1'b0;
         bvalid_q   <= 1'b0;
         ar_rdy_q   <= 1'b0;
         rvalid_q   <= 1'b0;
         op_start_q <= 1'b0;
         mem_addr_q <= '0;
         mem_len_q  <= '0;
         cfg_q      <= '0;
      end else begin
         // Ready pulses one cycle after both valids
         aw_rdy_q <= s_axi_awvalid_i & s_axi_wvalid_i & ~aw_rdy_q & ~bvalid_q;
         ar_rdy_q <= s_axi_arvalid_i & ~ar_rdy_q & ~rvalid_q;

         if (wr_hs) begin
            bvalid_q <= 1'b1;
         end else if (s_axi_bready_i) begin
            bvalid_q <= 1'b0;
         end

         if (rd_hs) begin
            rvalid_q <= 1'b1;
         end else if (s_axi_rready_i) begin
            rvalid_q <= 1'b0;
         end

         op_start_q <= wr_hs && (s_axi_awaddr_i == `REG_TPROC_CFG) && wr_cfg.start;

         if (wr_hs) begin
            case (s_axi_awaddr_i)
               `REG_MEM_ADDR:  mem_addr_q <= s_axi_wdata_i[`MEM_ADDR_W-1:0];
               `REG_MEM_LEN:   mem_len_q  <= s_axi_wdata_i[`MEM_ADDR_W-1:0];
               `REG_TPROC_CFG: cfg_q      <= wr_cfg;
               default: ;     // Unmapped, dropped
            endcase
         end
      end
   end

   // Data words
   always_ff @(posedge s_ps_dma_aclk) begin
      if (wr_hs && (s_axi_awaddr_i == `REG_MEM_DT_I)) begin
         mem_dt_i_q <= s_axi_wdata_i;
      end
      if (cfg_if.rd_valid) begin
         mem_dt_o_q <= cfg_if.rd_data;
      end
      if (rd_hs) begin
         rdata_q <= rd_mux;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read decode

   always_comb begin
      case (s_axi_araddr_i)
         `REG_MEM_ADDR:     rd_mux = {{PAD_A{1'b0}}, mem_addr_q};
         `REG_MEM_LEN:      rd_mux = {{PAD_A{1'b0}}, mem_len_q};
         `REG_MEM_DT_I:     rd_mux = mem_dt_i_q;
         `REG_TPROC_CFG:    rd_mux = {{PAD_C{1'b0}}, cfg_q};
         `REG_MEM_DT_O:     rd_mux = mem_dt_o_q;
         `REG_TPROC_STATUS: rd_mux = {{(`QPROC_DW-1){1'b0}}, cfg_if.busy};
         default:           rd_mux = '0;
      endcase
   end

   assign s_axi_awready_o = aw_rdy_q;
   assign s_axi_wready_o  = aw_rdy_q;
   assign s_axi_bvalid_o  = bvalid_q;
   assign s_axi_bresp_o   = 2'b00;   // OKAY
   assign s_axi_arready_o = ar_rdy_q;
   assign s_axi_rvalid_o  = rvalid_q;
   assign s_axi_rdata_o   = rdata_q;
   assign s_axi_rresp_o   = 2'b00;

   assign cfg_if.op_start  = op_start_q;
   assign cfg_if.cfg       = cfg_q;
   assign cfg_if.base_addr = mem_addr_q;
   assign cfg_if.len       = mem_len_q;
   assign cfg_if.wr_data   = mem_dt_i_q;

endmodule

/* hw/mem_access_ctrl.sv */
`include "qproc_mem_defines.svh"

module mem_access_ctrl (
   input  logic                 s_ps_dma_aclk,
   input  logic                 rst_n_i,
   mem_cfg_if.ctrl              cfg_if,
   mem_port_if.master           mem_if,
   input  logic [`QPROC_DW-1:0] s_dma_tdata_i,
   input  logic                 s_dma_tvalid_i,
   output logic                 s_dma_tready_o,
   output logic [`QPROC_DW-1:0] m_dma_tdata_o,
   output logic                 m_dma_tvalid_o,
   output logic                 m_dma_tlast_o,
   input  logic                 m_dma_tready_i
);
   import qproc_mem_pkg::*;

   ctrl_state_t            state;
   logic [`MEM_ADDR_W-1:0] beat_cnt;   // Beats left to move or issue
   logic [`MEM_ADDR_W-1:0] addr_cnt;
   mem_sel_t               op_sel;
   logic                   op_write;
   logic                   rd_pend;    // rdata valid this cycle
   logic                   last_pend;
   logic                   out_valid, out_last;
   logic [`QPROC_DW-1:0]   out_data;

   logic s_tready, sgl_issue, wr_beat, rd_issue, out_take;

   assign s_tready  = (state == STR_WR) && (beat_cnt != '0);
   assign sgl_issue = (state == SGL) && !rd_pend;
   assign wr_beat   = s_tready && s_dma_tvalid_i;
   assign out_take  = out_valid && m_dma_tready_i;
   // Only read when the output register is free by the time data lands
   assign rd_issue  = (state == STR_RD) && (beat_cnt != '0) && !rd_pend &&
                      (!out_valid || m_dma_tready_i);

   //////////////////////////////////////////////////////////////////////
   // FSM

   always_ff @(posedge s_ps_dma_aclk) begin
      if (!rst_n_i) begin
         state     <= IDLE;
         beat_cnt  <= '0;
         rd_pend   <= 1'b0;
         last_pend <= 1'b0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
      end else begin
         rd_pend <= mem_if.en & ~mem_if.we;
         case (state)
            IDLE: begin
               if (cfg_if.op_start) begin
                  beat_cnt <= cfg_if.len;
                  if (cfg_if.cfg.single)     state <= SGL;
                  else if (cfg_if.cfg.write) state <= STR_WR;
                  else                       state <= STR_RD;
               end
            end
            SGL: begin
               if (op_write || rd_pend) state <= IDLE;
            end
            STR_WR: begin
               if (beat_cnt == '0) begin
                  state <= IDLE;   // Zero length
               end else if (wr_beat) begin
                  beat_cnt <= beat_cnt - 1'b1;
                  if (beat_cnt == `MEM_ADDR_W'(1)) state <= IDLE;
               end
            end
            STR_RD: begin
               if (rd_issue) begin
                  beat_cnt  <= beat_cnt - 1'b1;
                  last_pend <= (beat_cnt == `MEM_ADDR_W'(1));
               end
               if (out_take && out_last) begin
                  state <= IDLE;
               end else if (beat_cnt == '0 && !rd_pend && !out_valid) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase

         // Output register flags
         if (state == STR_RD && rd_pend) begin
            out_valid <= 1'b1;
            out_last  <= last_pend;
         end else if (out_take) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
         end
      end
   end

   // Address, op latch and output word
   always_ff @(posedge s_ps_dma_aclk) begin
      if (state == IDLE && cfg_if.op_start) begin
         addr_cnt <= cfg_if.base_addr;
         op_sel   <= cfg_if.cfg.sel;
         op_write <= cfg_if.cfg.write;
      end else if (mem_if.en) begin
         addr_cnt <= addr_cnt + 1'b1;   // Wraps in the bank
      end
      if (state == STR_RD && rd_pend) begin
         out_data <= mem_if.rdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Outputs

   assign mem_if.en    = sgl_issue | wr_beat | rd_issue;
   assign mem_if.we    = (sgl_issue & op_write) | wr_beat;
   assign mem_if.sel   = op_sel;
   assign mem_if.addr  = addr_cnt;
   assign mem_if.wdata = (state == SGL) ? cfg_if.wr_data : s_dma_tdata_i;

   assign cfg_if.busy     = (state != IDLE);
   assign cfg_if.rd_data  = mem_if.rdata;
   assign cfg_if.rd_valid = (state == SGL) && rd_pend;

   assign s_dma_tready_o = s_tready;
   assign m_dma_tdata_o  = out_data;
   assign m_dma_tvalid_o = out_valid;
   assign m_dma_tlast_o  = out_last;

endmodule

/* hw/qproc_mem_bank.sv */
`include "qproc_mem_defines.svh"

module qproc_mem_bank (
   input  logic      s_ps_dma_aclk,
   mem_port_if.slave mem_if
);
   import qproc_mem_pkg::*;

   logic [`QPROC_DW-1:0] pmem [2**`PMEM_AW];   // Program
   logic [`QPROC_DW-1:0] dmem [2**`DMEM_AW];   // Data
   logic [`QPROC_DW-1:0] wmem [2**`WMEM_AW];   // Wave
   logic [`QPROC_DW-1:0] rdata_q;

   logic [`PMEM_AW-1:0] p_addr;
   logic [`DMEM_AW-1:0] d_addr;
   logic [`WMEM_AW-1:0] w_addr;

   // Low address bits only
   assign p_addr = mem_if.addr[`PMEM_AW-1:0];
   assign d_addr = mem_if.addr[`DMEM_AW-1:0];
   assign w_addr = mem_if.addr[`WMEM_AW-1:0];

   always_ff @(posedge s_ps_dma_aclk) begin
      if (mem_if.en) begin
         case (mem_if.sel)
            MEM_PMEM: begin
               if (mem_if.we) pmem[p_addr] <= mem_if.wdata;
               rdata_q <= pmem[p_addr];
            end
            MEM_DMEM: begin
               if (mem_if.we) dmem[d_addr] <= mem_if.wdata;
               rdata_q <= dmem[d_addr];
            end
            MEM_WMEM: begin
               if (mem_if.we) wmem[w_addr] <= mem_if.wdata;
               rdata_q <= wmem[w_addr];
            end
            default: rdata_q <= '0;   // MEM_NONE touches nothing
         endcase
      end
   end

   assign mem_if.rdata = rdata_q;

endmodule

/* hw/qproc_mem_top.sv */
`include "qproc_mem_defines.svh"

module qproc_mem_top (
   input  logic                    s_ps_dma_aclk,
   input  logic                    rst_n_i,
   // AXI-Lite slave
   input  logic [`QPROC_AXI_AW-1:0] s_axi_awaddr_i,
   input  logic                    s_axi_awvalid_i,
   output logic                    s_axi_awready_o,
   input  logic [`QPROC_DW-1:0]    s_axi_wdata_i,
   input  logic                    s_axi_wvalid_i,
   output logic                    s_axi_wready_o,
   output logic                    s_axi_bvalid_o,
   output logic [1:0]              s_axi_bresp_o,
   input  logic                    s_axi_bready_i,
   input  logic [`QPROC_AXI_AW-1:0] s_axi_araddr_i,
   input  logic                    s_axi_arvalid_i,
   output logic                    s_axi_arready_o,
   output logic                    s_axi_rvalid_o,
   output logic [`QPROC_DW-1:0]    s_axi_rdata_o,
   output logic [1:0]              s_axi_rresp_o,
   input  logic                    s_axi_rready_i,
   // DMA streams
   input  logic [`QPROC_DW-1:0]    s_dma_tdata_i,
   input  logic                    s_dma_tvalid_i,
   output logic                    s_dma_tready_o,
   output logic [`QPROC_DW-1:0]    m_dma_tdata_o,
   output logic                    m_dma_tvalid_o,
   output logic                    m_dma_tlast_o,
   input  logic                    m_dma_tready_i
);

   mem_cfg_if  cfg_if ();
   mem_port_if port_if ();

   axil_reg_file reg_file_i (
      .s_ps_dma_aclk   (s_ps_dma_aclk),
      .rst_n_i         (rst_n_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bresp_o   (s_axi_bresp_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rresp_o   (s_axi_rresp_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .cfg_if          (cfg_if)
   );

   mem_access_ctrl ctrl_i (
      .s_ps_dma_aclk  (s_ps_dma_aclk),
      .rst_n_i        (rst_n_i),
      .cfg_if         (cfg_if),
      .mem_if         (port_if),
      .s_dma_tdata_i  (s_dma_tdata_i),
      .s_dma_tvalid_i (s_dma_tvalid_i),
      .s_dma_tready_o (s_dma_tready_o),
      .m_dma_tdata_o  (m_dma_tdata_o),
      .m_dma_tvalid_o (m_dma_tvalid_o),
      .m_dma_tlast_o  (m_dma_tlast_o),
      .m_dma_tready_i (m_dma_tready_i)
   );

   qproc_mem_bank bank_i (
      .s_ps_dma_aclk (s_ps_dma_aclk),
      .mem_if        (port_if)
   );

endmodule

/* verif/tb_clk_gen.sv */
module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;   // Period 100
   end

   // Reset held over two rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      #1 rst_n_o = 1'b1;
   end

endmodule

/* verif/qproc_mem_chk.sv */
`include "qproc_mem_defines.svh"

module qproc_mem_chk (
   input logic                       clk_i,
   input logic                       rst_n_i,
   input logic                       bvalid_i,
   input logic                       bready_i,
   input logic                       rvalid_i,
   input logic                       rready_i,
   input logic [`QPROC_DW-1:0]       m_tdata_i,
   input logic                       m_tvalid_i,
   input logic                       m_tlast_i,
   input logic                       m_tready_i,
   input logic                       s_tready_i,
   input qproc_mem_pkg::ctrl_state_t state_i
);
   import qproc_mem_pkg::*;

   int fail_cnt = 0;   // Read by the testbench at the end

   //////////////////////////////////////////////////////////////////////
   // AXI-Lite responses

   b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bvalid_i && !bready_i |=> bvalid_i)
      else begin
         $error("bvalid dropped before bready");
         fail_cnt++;
      end

   r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i && !rready_i |=> rvalid_i)
      else begin
         $error("rvalid dropped before rready");
         fail_cnt++;
      end

   //////////////////////////////////////////////////////////////////////
   // DMA streams

   // Output beat frozen under back-pressure
   m_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i))
      else begin
         $error("m_dma beat changed while stalled");
         fail_cnt++;
      end

   // No stream handshake outside an operation
   s_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      state_i == IDLE |-> !s_tready_i && !m_tvalid_i)
      else begin
         $error("DMA stream active in IDLE");
         fail_cnt++;
      end

endmodule

/* verif/tb_qproc_mem.sv */
`include "qproc_mem_defines.svh"

module tb_qproc_mem;
   import qproc_mem_pkg::*;

   localparam int NUM_STR = 6;     // Stream write and read pairs
   localparam int MAX_LEN = 12;
   localparam int NUM_AXI = 200;   // Upper count of AXI transactions
   localparam int TIMEOUT = NUM_AXI * 40 + NUM_STR * 2 * MAX_LEN * 20 + 200;

   logic                     s_ps_dma_aclk, rst_n_i;
   logic [`QPROC_AXI_AW-1:0] s_axi_awaddr_i, s_axi_araddr_i;
   logic                     s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i;
   logic                     s_axi_arvalid_i, s_axi_rready_i;
   logic [`QPROC_DW-1:0]     s_axi_wdata_i, s_axi_rdata_o;
   logic                     s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o;
   logic                     s_axi_arready_o, s_axi_rvalid_o;
   logic [1:0]               s_axi_bresp_o, s_axi_rresp_o;
   logic [`QPROC_DW-1:0]     s_dma_tdata_i, m_dma_tdata_o;
   logic                     s_dma_tvalid_i, s_dma_tready_o;
   logic                     m_dma_tvalid_o, m_dma_tlast_o, m_dma_tready_i;
   int unsigned              cycles = 0;

   // Reference model of the three memories
   logic [`QPROC_DW-1:0] pmem_m [2**`PMEM_AW];
   logic [`QPROC_DW-1:0] dmem_m [2**`DMEM_AW];
   logic [`QPROC_DW-1:0] wmem_m [2**`WMEM_AW];

   tb_clk_gen clk_gen_i (.clk_o(s_ps_dma_aclk), .rst_n_o(rst_n_i));

   qproc_mem_top dut_i (.*);

   bind qproc_mem_top qproc_mem_chk chk_i (
      .clk_i      (s_ps_dma_aclk),
      .rst_n_i    (rst_n_i),
      .bvalid_i   (s_axi_bvalid_o),
      .bready_i   (s_axi_bready_i),
      .rvalid_i   (s_axi_rvalid_o),
      .rready_i   (s_axi_rready_i),
      .m_tdata_i  (m_dma_tdata_o),
      .m_tvalid_i (m_dma_tvalid_o),
      .m_tlast_i  (m_dma_tlast_o),
      .m_tready_i (m_dma_tready_i),
      .s_tready_i (s_dma_tready_o),
      .state_i    (ctrl_i.state)
   );

   //////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_word(input string name, input logic [`QPROC_DW-1:0] exp, act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
         $display("Checks failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
         $display("Checks failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] exp, act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
         $display("Checks failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Model and bus drivers

   task automatic model_write(input mem_sel_t sel, input logic [`MEM_ADDR_W-1:0] a,
                              input logic [`QPROC_DW-1:0] d);
      case (sel)
         MEM_PMEM: pmem_m[a[`PMEM_AW-1:0]] = d;
         MEM_DMEM: dmem_m[a[`DMEM_AW-1:0]] = d;
         MEM_WMEM: wmem_m[a[`WMEM_AW-1:0]] = d;
         default: ;
      endcase
   endtask

   function automatic logic [`QPROC_DW-1:0] model_read(mem_sel_t sel,
                                                       logic [`MEM_ADDR_W-1:0] a);
      case (sel)
         MEM_PMEM: return pmem_m[a[`PMEM_AW-1:0]];
         MEM_DMEM: return dmem_m[a[`DMEM_AW-1:0]];
         MEM_WMEM: return wmem_m[a[`WMEM_AW-1:0]];
         default:  return '0;
      endcase
   endfunction

   // TPROC_CFG word with start set
   function automatic logic [`QPROC_DW-1:0] cfg_word(logic write, mem_sel_t sel, logic single);
      mem_cfg_t c;
      c = '{single: single, sel: sel, write: write, start: 1'b1};
      return `QPROC_DW'(c);
   endfunction

   // Outputs seen here are what the next edge samples
   task automatic next_cycle();
      @(posedge s_ps_dma_aclk);
      #1;
   endtask

   task automatic idle_gap();
      repeat ($urandom % 3) next_cycle();
   endtask

   task automatic axi_write(input logic [`QPROC_AXI_AW-1:0] addr,
                            input logic [`QPROC_DW-1:0] data);
      idle_gap();
      s_axi_awaddr_i  = addr;
      s_axi_wdata_i   = data;
      s_axi_awvalid_i = 1'b1;
      s_axi_wvalid_i  = 1'b1;
      do begin
         next_cycle();
      end while (!s_axi_awready_o);
      check_bit("s_axi_wready_o", 1'b1, s_axi_wready_o);
      next_cycle();
      s_axi_awvalid_i = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      forever begin
         s_axi_bready_i = ($urandom % 4) != 0;
         if (s_axi_bvalid_o && s_axi_bready_i) break;
         next_cycle();
      end
      check_resp("s_axi_bresp_o", 2'b00, s_axi_bresp_o);
      next_cycle();
      s_axi_bready_i = 1'b0;
   endtask

   task automatic axi_read(input logic [`QPROC_AXI_AW-1:0] addr,
                           output logic [`QPROC_DW-1:0] data);
      idle_gap();
      s_axi_araddr_i  = addr;
      s_axi_arvalid_i = 1'b1;
      do begin
         next_cycle();
      end while (!s_axi_arready_o);
      next_cycle();
      s_axi_arvalid_i = 1'b0;
      forever begin
         s_axi_rready_i = ($urandom % 4) != 0;
         if (s_axi_rvalid_o && s_axi_rready_i) break;
         next_cycle();
      end
      data = s_axi_rdata_o;
      check_resp("s_axi_rresp_o", 2'b00, s_axi_rresp_o);
      next_cycle();
      s_axi_rready_i = 1'b0;
   endtask

   task automatic wait_idle();
      logic [`QPROC_DW-1:0] status;
      do begin
         axi_read(`REG_TPROC_STATUS, status);
      end while (status[0]);
   endtask

   task automatic single_write(input mem_sel_t sel, input logic [`MEM_ADDR_W-1:0] a,
                               input logic [`QPROC_DW-1:0] d);
      axi_write(`REG_MEM_ADDR, `QPROC_DW'(a));
      axi_write(`REG_MEM_DT_I, d);
      axi_write(`REG_TPROC_CFG, cfg_word(1'b1, sel, 1'b1));
      wait_idle();
      model_write(sel, a, d);
   endtask

   task automatic single_read_check(input mem_sel_t sel, input logic [`MEM_ADDR_W-1:0] a);
      logic [`QPROC_DW-1:0] d;
      axi_write(`REG_MEM_ADDR, `QPROC_DW'(a));
      axi_write(`REG_TPROC_CFG, cfg_word(1'b0, sel, 1'b1));
      wait_idle();
      axi_read(`REG_MEM_DT_O, d);
      check_word("MEM_DT_O", model_read(sel, a), d);
   endtask

   task automatic send_beat(input logic [`QPROC_DW-1:0] data);
      idle_gap();
      s_dma_tdata_i  = data;
      s_dma_tvalid_i = 1'b1;
      while (!s_dma_tready_o) next_cycle();
      next_cycle();
      s_dma_tvalid_i = 1'b0;
   endtask

   task automatic take_beat(input logic [`QPROC_DW-1:0] exp, input logic last);
      forever begin
         m_dma_tready_i = ($urandom % 3) != 0;
         if (m_dma_tvalid_o && m_dma_tready_i) break;
         next_cycle();
      end
      check_word("m_dma_tdata_o", exp, m_dma_tdata_o);
      check_bit("m_dma_tlast_o", last, m_dma_tlast_o);
      next_cycle();
      m_dma_tready_i = 1'b0;
   endtask

   // Stream write with busy checks, then stream read of the same range
   task automatic stream_test(input mem_sel_t sel, input logic [`MEM_ADDR_W-1:0] base,
                              input int len);
      logic [`QPROC_DW-1:0] status, word;
      logic [`MEM_ADDR_W-1:0] a;
      axi_write(`REG_MEM_ADDR, `QPROC_DW'(base));
      axi_write(`REG_MEM_LEN, `QPROC_DW'(len));
      axi_write(`REG_TPROC_CFG, cfg_word(1'b1, sel, 1'b0));
      for (int i = 0; i < len; i++) begin
         if (i == len - 1) begin
            axi_read(`REG_TPROC_STATUS, status);
            check_bit("TPROC_STATUS[0]", 1'b1, status[0]);
         end
         word = $urandom;
         send_beat(word);
         model_write(sel, `MEM_ADDR_W'(base + i), word);
      end
      axi_read(`REG_TPROC_STATUS, status);
      check_bit("TPROC_STATUS[0]", 1'b0, status[0]);
      axi_write(`REG_TPROC_CFG, cfg_word(1'b0, sel, 1'b0));
      for (int i = 0; i < len; i++) begin
         a = `MEM_ADDR_W'(base + i);
         take_beat(model_read(sel, a), i == len - 1);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [`QPROC_DW-1:0]   d, v;
      logic [`MEM_ADDR_W-1:0] a;
      int                     unused [6];
      void'($urandom(32'h0604f621));
      s_axi_awaddr_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b0;
      s_axi_araddr_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b0;
      s_dma_tdata_i   = '0;
      s_dma_tvalid_i  = 1'b0;
      m_dma_tready_i  = 1'b0;
      unused = '{0, 20, 24, 36, 60, 252};
      @(posedge rst_n_i);
      next_cycle();

      for (int m = 1; m <= 3; m++) begin   // Single write and read per memory
         a = `MEM_ADDR_W'($urandom);
         single_write(mem_sel_t'(m), a, $urandom);
         single_read_check(mem_sel_t'(m), a);
      end

      for (int n = 0; n < NUM_STR; n++) begin
         stream_test(mem_sel_t'(1 + n % 3), `MEM_ADDR_W'($urandom), 1 + $urandom % MAX_LEN);
      end

      // Same address, separate memories
      a = `MEM_ADDR_W'($urandom % 16);
      v = $urandom;
      for (int m = 1; m <= 3; m++) single_write(mem_sel_t'(m), a, v + m);
      for (int m = 1; m <= 3; m++) single_read_check(mem_sel_t'(m), a);

      a = `MEM_ADDR_W'($urandom % 16);   // DMEM wrap
      single_write(MEM_DMEM, a + 16, $urandom);
      single_read_check(MEM_DMEM, a);

      v = $urandom % 65536;
      axi_write(`REG_MEM_ADDR, v);
      axi_read(`REG_MEM_ADDR, d);
      check_word("MEM_ADDR", v, d);
      v = $urandom % 65536;
      axi_write(`REG_MEM_LEN, v);
      axi_read(`REG_MEM_LEN, d);
      check_word("MEM_LEN", v, d);
      v = ($urandom % 32) & 32'hFFFF_FFFE;   // Start clear, no transfer
      axi_write(`REG_TPROC_CFG, v);
      axi_read(`REG_TPROC_CFG, d);
      check_word("TPROC_CFG", v, d);
      foreach (unused[i]) begin
         axi_write(`QPROC_AXI_AW'(unused[i]), $urandom);
         axi_read(`QPROC_AXI_AW'(unused[i]), d);
         check_word("unused register", '0, d);
      end

      if (dut_i.chk_i.fail_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("The handshake checker reported assertion failures");
         $display("Checks failed");
         $fatal(1, "Assertion failures");
      end
   end

   always @(posedge s_ps_dma_aclk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
         $display("Checks failed");
         $fatal(1, "Simulation timed out");
      end
   end

endmodule

/* filelist.f */
+incdir+hw
hw/qproc_mem_pkg.sv
hw/qproc_mem_ifs.sv
hw/axil_reg_file.sv
hw/mem_access_ctrl.sv
hw/qproc_mem_bank.sv
hw/qproc_mem_top.sv
verif/tb_clk_gen.sv
verif/qproc_mem_chk.sv
verif/tb_qproc_mem.sv

/* Bender.yml */
package:
  name: qproc_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/qproc_mem_pkg.sv
      - hw/qproc_mem_ifs.sv
      - hw/axil_reg_file.sv
      - hw/mem_access_ctrl.sv
      - hw/qproc_mem_bank.sv
      - hw/qproc_mem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_clk_gen.sv
      - verif/qproc_mem_chk.sv
      - verif/tb_qproc_mem.sv
